// ==== Bender.yml ====
package:
  name: ctrl

sources:
  - rtl/ctrl_pkg.sv
  - rtl/exc_detect.sv
  - rtl/irq_arbiter.sv
  - rtl/ctrl_fsm.sv
  - rtl/ctrl_top.sv
  - target: simulation
    files:
      - sim/ctrl_assertions.sv
      - sim/tb_ctrl.sv

// ==== rtl/ctrl_fsm.sv ====
//////////////////////////////
// controller state machine
// pc select, csr strobes, nmi mode and IF/ID stall control
//////////////////////////////

`default_nettype none

module ctrl_fsm
  import ctrl_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            instr_valid_i,
  input  exc_info_t       exc_i,
  input  irq_info_t       irq_i,
  input  logic            branch_set_i,
  input  logic            jump_set_i,
  input  logic            stall_id_i,
  input  priv_lvl_e       priv_mode_i,
  output logic            ctrl_busy_o,
  output logic            instr_req_o,
  output logic            id_in_ready_o,
  output logic            instr_valid_clear_o,
  output logic            flush_id_o,
  output logic            controller_run_o,
  output logic            pc_set_o,
  output pc_sel_e         pc_mux_o,
  output exc_pc_sel_e     exc_pc_mux_o,
  output exc_cause_u      exc_cause_o,
  output logic [xlen-1:0] csr_mtval_o,
  output csr_ctrl_t       csr_o,
  output logic            nmi_mode_o,
  output logic            in_flush_o
);

  typedef enum logic [2:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN
  } ctrl_fsm_e;

  ctrl_fsm_e ctrl_fsm_cs, ctrl_fsm_ns;
  logic      nmi_mode_d, nmi_mode_q;
  logic      halt_if, retain_id, flush_id;
  logic      mret_ok;

  // mret only returns from M-mode, the U-mode case traps as illegal
  assign mret_ok = exc_i.mret & (priv_mode_i == PRIV_LVL_M);

  always_comb begin
    ctrl_fsm_ns      = ctrl_fsm_cs;
    nmi_mode_d       = nmi_mode_q;
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    controller_run_o = 1'b0;
    // mux selects only matter while pc_set_o is high
    pc_set_o         = 1'b0;
    pc_mux_o         = PC_BOOT;
    exc_pc_mux_o     = EXC_PC_IRQ;
    exc_cause_o      = '0;
    csr_mtval_o      = '0;
    csr_o            = '0;
    halt_if          = 1'b0;
    retain_id        = 1'b0;
    flush_id         = 1'b0;

    unique case (ctrl_fsm_cs)
      RESET: begin
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        ctrl_fsm_ns = BOOT_SET;
      end

      BOOT_SET: begin
        // boot address into the fetch unit
        pc_set_o    = 1'b1;
        ctrl_fsm_ns = FIRST_FETCH;
      end

      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        ctrl_fsm_ns = SLEEP;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // stay clock gated until some request shows up
        if (irq_i.wake) begin
          ctrl_fsm_ns = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end

      FIRST_FETCH: begin
        // wait out an IF miss
        if (!stall_id_i) begin
          ctrl_fsm_ns = DECODE;
        end
        // interrupt wins, IF halts until the redirect
        if (irq_i.take) begin
          ctrl_fsm_ns = IRQ_TAKEN;
          halt_if     = 1'b1;
        end
      end

      DECODE: begin
        controller_run_o = 1'b1;
        pc_mux_o         = PC_JUMP;

        // keep the instruction in ID so FLUSH can still see it
        if (exc_i.special_req) begin
          retain_id = 1'b1;
          if (!stall_id_i) begin
            ctrl_fsm_ns = FLUSH;
          end
        end

        // branches and jumps redirect right away
        if (branch_set_i || jump_set_i) begin
          pc_set_o = 1'b1;
        end

        // a pending irq waits for ID to drain
        if (irq_i.take && (stall_id_i || instr_valid_i)) begin
          halt_if = 1'b1;
        end

        if (irq_i.take && !stall_id_i && !exc_i.special_req && !instr_valid_i) begin
          ctrl_fsm_ns = IRQ_TAKEN;
          halt_if     = 1'b1;
        end
      end

      IRQ_TAKEN: begin
        pc_mux_o     = PC_EXC;
        exc_pc_mux_o = EXC_PC_IRQ;
        if (irq_i.take) begin
          pc_set_o           = 1'b1;
          csr_o.save_if      = 1'b1;
          csr_o.save_cause   = 1'b1;
          exc_cause_o        = irq_i.cause;
          // nmi handler runs without nesting
          if (irq_i.cause.code == EXC_CAUSE_IRQ_NM) begin
            nmi_mode_d = 1'b1;
          end
        end
        ctrl_fsm_ns = DECODE;
      end

      FLUSH: begin
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        ctrl_fsm_ns = DECODE;

        if (exc_i.trap_pending) begin
          // exception vector, epc from the instruction in ID
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          exc_pc_mux_o     = EXC_PC_EXC;
          csr_o.save_id    = 1'b1;
          csr_o.save_cause = 1'b1;
          exc_cause_o      = exc_i.cause;
          csr_mtval_o      = exc_i.mtval;
        end else if (mret_ok) begin
          pc_set_o           = 1'b1;
          pc_mux_o           = PC_ERET;
          csr_o.restore_mret = 1'b1;
          // mret also leaves the nmi handler
          nmi_mode_d         = 1'b0;
        end else if (exc_i.wfi) begin
          ctrl_fsm_ns = WAIT_SLEEP;
        end else if (exc_i.csr_flush && irq_i.take) begin
          // csr writes may have just enabled an interrupt
          ctrl_fsm_ns = IRQ_TAKEN;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        ctrl_fsm_ns = RESET;
      end
    endcase
  end

  //////////////////////////////
  // stall control
  //////////////////////////////

  assign id_in_ready_o       = ~stall_id_i & ~halt_if & ~retain_id;
  // retain keeps valid set unless the flush kills it anyway
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;
  assign flush_id_o          = flush_id;
  assign nmi_mode_o          = nmi_mode_q;
  assign in_flush_o          = (ctrl_fsm_cs == FLUSH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_fsm_cs <= RESET;
      nmi_mode_q  <= 1'b0;
    end else begin
      ctrl_fsm_cs <= ctrl_fsm_ns;
      nmi_mode_q  <= nmi_mode_d;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ctrl_pkg.sv ====
//////////////////////////////
// controller package
// widths, enums and structs shared by the core control blocks
//////////////////////////////

`default_nettype none

package ctrl_pkg;

  // data and address word width
  localparam int unsigned xlen = 32;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // fetch address source
  typedef enum logic [1:0] {
    PC_BOOT = 2'b00,
    PC_JUMP = 2'b01,
    PC_EXC  = 2'b10,
    PC_ERET = 2'b11
  } pc_sel_e;

  // vector base for exceptions vs interrupts
  typedef enum logic [0:0] {
    EXC_PC_EXC = 1'b0,
    EXC_PC_IRQ = 1'b1
  } exc_pc_sel_e;

  //////////////////////////////
  // trap causes
  //////////////////////////////

  // msb marks an interrupt, bit 4 marks a fast or nm interrupt
  typedef enum logic [5:0] {
    EXC_CAUSE_INSTR_ACCESS_FAULT = 6'd1,
    EXC_CAUSE_ILLEGAL_INSN       = 6'd2,
    EXC_CAUSE_BREAKPOINT         = 6'd3,
    EXC_CAUSE_LOAD_ACCESS_FAULT  = 6'd5,
    EXC_CAUSE_STORE_ACCESS_FAULT = 6'd7,
    EXC_CAUSE_ECALL_UMODE        = 6'd8,
    EXC_CAUSE_ECALL_MMODE        = 6'd11,
    EXC_CAUSE_IRQ_SOFTWARE_M     = {1'b1, 5'd3},
    EXC_CAUSE_IRQ_TIMER_M        = {1'b1, 5'd7},
    EXC_CAUSE_IRQ_EXTERNAL_M     = {1'b1, 5'd11},
    EXC_CAUSE_IRQ_NM             = {1'b1, 5'd31}
  } exc_code_e;

  // field view of an interrupt cause
  typedef struct packed {
    logic       irq;
    logic       fast;
    logic [3:0] id;
  } irq_cause_t;

  // exceptions decode the code view, interrupts build through the field view
  typedef union packed {
    exc_code_e  code;
    irq_cause_t fields;
  } exc_cause_u;

  //////////////////////////////
  // bundles
  //////////////////////////////

  // requests already qualified with mie
  typedef struct packed {
    logic        irq_software;
    logic        irq_timer;
    logic        irq_external;
    logic [14:0] irq_fast;
  } irqs_t;

  // instruction sitting in the IF/ID register
  typedef struct packed {
    logic            valid;
    logic            illegal;
    logic            ecall;
    logic            mret;
    logic            wfi;
    logic            ebreak;
    logic            csr_flush;
    logic            fetch_err;
    logic            fetch_err_plus2;
    logic            is_compressed;
    logic [31:0]     instr;
    logic [15:0]     instr_c;
    logic [xlen-1:0] pc;
  } instr_info_t;

  typedef struct packed {
    logic            load_err;
    logic            store_err;
    logic [xlen-1:0] addr_last;
  } lsu_err_t;

  // csr save and restore strobes
  typedef struct packed {
    logic save_if;
    logic save_id;
    logic save_cause;
    logic restore_mret;
  } csr_ctrl_t;

  typedef struct packed {
    logic            special_req;
    logic            trap_pending;
    logic            mret;
    logic            wfi;
    logic            csr_flush;
    exc_cause_u      cause;
    logic [xlen-1:0] mtval;
  } exc_info_t;

  typedef struct packed {
    logic       take;
    logic       wake;
    exc_cause_u cause;
  } irq_info_t;

endpackage

`default_nettype wire

// ==== rtl/ctrl_top.sv ====
//////////////////////////////
// core controller top level
// exception detection, interrupt arbiter and main FSM
//////////////////////////////

`default_nettype none

module ctrl_top
  import ctrl_pkg::*;
#(
  parameter int unsigned NumFastIrq = 15
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  // IF/ID register and LSU
  input  instr_info_t     instr_i,
  input  lsu_err_t        lsu_i,
  // interrupts and csr state
  input  irqs_t           irqs_i,
  input  logic            irq_nm_i,
  input  priv_lvl_e       priv_mode_i,
  input  logic            csr_mstatus_mie_i,
  input  logic            csr_mstatus_tw_i,
  // execute side
  input  logic            branch_set_i,
  input  logic            jump_set_i,
  input  logic            stall_id_i,
  output logic            ctrl_busy_o,
  output logic            instr_req_o,
  output logic            id_in_ready_o,
  output logic            instr_valid_clear_o,
  output logic            flush_id_o,
  output logic            controller_run_o,
  output logic            pc_set_o,
  output pc_sel_e         pc_mux_o,
  output exc_pc_sel_e     exc_pc_mux_o,
  output exc_cause_u      exc_cause_o,
  output logic [xlen-1:0] csr_mtval_o,
  output csr_ctrl_t       csr_o,
  output logic            nmi_mode_o
);

  exc_info_t exc_info;
  irq_info_t irq_info;
  logic      in_flush;

  exc_detect u_exc_detect (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_i          (instr_i),
    .lsu_i            (lsu_i),
    .priv_mode_i      (priv_mode_i),
    .csr_mstatus_tw_i (csr_mstatus_tw_i),
    .in_flush_i       (in_flush),
    .exc_o            (exc_info)
  );

  // nmi mode feeds back from the FSM
  irq_arbiter #(
    .NumFastIrq (NumFastIrq)
  ) u_irq_arbiter (
    .irqs_i            (irqs_i),
    .irq_nm_i          (irq_nm_i),
    .csr_mstatus_mie_i (csr_mstatus_mie_i),
    .nmi_mode_i        (nmi_mode_o),
    .irq_o             (irq_info)
  );

  ctrl_fsm u_ctrl_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_i.valid),
    .exc_i               (exc_info),
    .irq_i               (irq_info),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .stall_id_i          (stall_id_i),
    .priv_mode_i         (priv_mode_i),
    .ctrl_busy_o         (ctrl_busy_o),
    .instr_req_o         (instr_req_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o),
    .controller_run_o    (controller_run_o),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .exc_pc_mux_o        (exc_pc_mux_o),
    .exc_cause_o         (exc_cause_o),
    .csr_mtval_o         (csr_mtval_o),
    .csr_o               (csr_o),
    .nmi_mode_o          (nmi_mode_o),
    .in_flush_o          (in_flush)
  );

endmodule

`default_nettype wire

// ==== rtl/exc_detect.sv ====
//////////////////////////////
// exception detection
// qualifies decoder and lsu flags, registers requests,
// picks the winning exception and forms cause and mtval
//////////////////////////////

`default_nettype none

module exc_detect
  import ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  instr_info_t instr_i,
  input  lsu_err_t    lsu_i,
  input  priv_lvl_e   priv_mode_i,
  input  logic        csr_mstatus_tw_i,
  input  logic        in_flush_i,
  output exc_info_t   exc_o
);

  logic ecall, mret, wfi, ebrk, csr_flush, fetch_err, illegal;
  logic illegal_umode;
  logic illegal_d, illegal_q;
  logic exc_req_d, exc_req_q;
  logic load_err_d, load_err_q;
  logic store_err_d, store_err_q;
  logic lsu_req;
  exc_cause_u      cause;
  logic [xlen-1:0] mtval;

  // decoder flags do not look at valid, qualify them here
  assign ecall     = instr_i.ecall     & instr_i.valid;
  assign mret      = instr_i.mret      & instr_i.valid;
  assign wfi       = instr_i.wfi       & instr_i.valid;
  assign ebrk      = instr_i.ebreak    & instr_i.valid;
  assign csr_flush = instr_i.csr_flush & instr_i.valid;
  assign fetch_err = instr_i.fetch_err & instr_i.valid;
  assign illegal   = instr_i.illegal   & instr_i.valid;

  // mret needs M-mode, tw traps wfi out of U-mode
  assign illegal_umode = (priv_mode_i != PRIV_LVL_M) & (mret | (csr_mstatus_tw_i & wfi));

  // requests are flopped and dropped while the flush handles them
  assign illegal_d = (illegal | illegal_umode) & ~in_flush_i;
  assign exc_req_d = (ecall | ebrk | illegal_d | fetch_err) & ~in_flush_i;

  // lsu errors are single pulses, hold them until the flush takes them
  assign load_err_d  = (lsu_i.load_err  | load_err_q)  & ~in_flush_i;
  assign store_err_d = (lsu_i.store_err | store_err_q) & ~in_flush_i;
  assign lsu_req     = lsu_i.load_err | lsu_i.store_err | load_err_q | store_err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q   <= 1'b0;
      exc_req_q   <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      illegal_q   <= illegal_d;
      exc_req_q   <= exc_req_d;
      load_err_q  <= load_err_d;
      store_err_q <= store_err_d;
    end
  end

  //////////////////////////////
  // prioritisation
  //////////////////////////////

  // order follows the privileged spec, instruction faults ahead of lsu faults
  always_comb begin
    cause = '0;
    mtval = '0;
    if (fetch_err) begin
      cause.code = EXC_CAUSE_INSTR_ACCESS_FAULT;
      mtval      = instr_i.fetch_err_plus2 ? instr_i.pc + xlen'(2) : instr_i.pc;
    end else if (illegal_q) begin
      cause.code = EXC_CAUSE_ILLEGAL_INSN;
      mtval      = instr_i.is_compressed ? xlen'(instr_i.instr_c) : xlen'(instr_i.instr);
    end else if (ecall) begin
      cause.code = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE : EXC_CAUSE_ECALL_UMODE;
    end else if (ebrk) begin
      // mtval stays zero for breakpoints
      cause.code = EXC_CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      cause.code = EXC_CAUSE_STORE_ACCESS_FAULT;
      mtval      = lsu_i.addr_last;
    end else if (load_err_q) begin
      cause.code = EXC_CAUSE_LOAD_ACCESS_FAULT;
      mtval      = lsu_i.addr_last;
    end
  end

  // anything that needs the pipeline flushed before going on
  assign exc_o.special_req  = mret | wfi | csr_flush | exc_req_d | lsu_req;
  assign exc_o.trap_pending = exc_req_q | load_err_q | store_err_q;
  assign exc_o.mret         = mret;
  assign exc_o.wfi          = wfi;
  assign exc_o.csr_flush    = csr_flush;
  assign exc_o.cause        = cause;
  assign exc_o.mtval        = mtval;

endmodule

`default_nettype wire

// ==== rtl/irq_arbiter.sv ====
//////////////////////////////
// interrupt arbiter
// decides if an interrupt is taken and encodes its cause
//////////////////////////////

`default_nettype none

module irq_arbiter
  import ctrl_pkg::*;
#(
  parameter int unsigned NumFastIrq = 15
) (
  input  irqs_t     irqs_i,
  input  logic      irq_nm_i,
  input  logic      csr_mstatus_mie_i,
  input  logic      nmi_mode_i,
  output irq_info_t irq_o
);

  // only the implemented fast lines take part
  localparam logic [14:0] fast_mask = 15'((1 << NumFastIrq) - 1);

  logic [14:0] fast_vec;
  logic [3:0]  fast_id;
  logic        irq_pending;
  exc_cause_u  cause;

  assign fast_vec    = irqs_i.irq_fast & fast_mask;
  assign irq_pending = irqs_i.irq_software | irqs_i.irq_timer | irqs_i.irq_external |
                       (|fast_vec);

  // highest fast id wins
  always_comb begin
    fast_id = 4'd0;
    for (int i = 0; i < 15; i++) begin
      if (fast_vec[i]) begin
        fast_id = 4'(i);
      end
    end
  end

  // nmi first, then fast, external, software, timer
  always_comb begin
    cause = '0;
    if (irq_nm_i) begin
      cause.code = EXC_CAUSE_IRQ_NM;
    end else if (|fast_vec) begin
      // fast causes sit at 16 + id
      cause.fields = '{irq: 1'b1, fast: 1'b1, id: fast_id};
    end else if (irqs_i.irq_external) begin
      cause.code = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irqs_i.irq_software) begin
      cause.code = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else begin
      cause.code = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

  // no nesting inside the nmi handler
  assign irq_o.take  = ~nmi_mode_i & (irq_nm_i | (irq_pending & csr_mstatus_mie_i));
  // sleep ends on any request, mie or not
  assign irq_o.wake  = irq_nm_i | irq_pending;
  assign irq_o.cause = cause;

endmodule

`default_nettype wire

// ==== sim/ctrl_assertions.sv ====
//////////////////////////////
// controller port assertions
// bound into the controller top level
//////////////////////////////

`default_nettype none

module ctrl_assertions
  import ctrl_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input logic      stall_id_i,
  input logic      id_ready_i,
  input logic      instr_req_i,
  input logic      pc_set_i,
  input pc_sel_e   pc_mux_i,
  input csr_ctrl_t csr_i,
  input logic      in_flush_i
);

  // running count of assertion failures
  int unsigned fail_count = 0;

  // redirects out of FLUSH and IRQ_TAKEN go to a vector or back from mret
  // save_if only ever pulses in IRQ_TAKEN
  a_trap_redirect_sel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i && (in_flush_i || csr_i.save_if) |-> (pc_mux_i == PC_EXC || pc_mux_i == PC_ERET))
    else begin
      fail_count++;
      $error("redirect from FLUSH or IRQ_TAKEN uses a wrong pc select");
    end

  // no fetch while held in reset
  a_no_fetch_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !instr_req_i)
    else begin
      fail_count++;
      $error("instruction request raised during reset");
    end

  a_stall_blocks_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_id_i |-> !id_ready_i)
    else begin
      fail_count++;
      $error("ID accepts a new instruction while stalled");
    end

endmodule

bind ctrl_top ctrl_assertions u_ctrl_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .stall_id_i  (stall_id_i),
  .id_ready_i  (id_in_ready_o),
  .instr_req_i (instr_req_o),
  .pc_set_i    (pc_set_o),
  .pc_mux_i    (pc_mux_o),
  .csr_i       (csr_o),
  .in_flush_i  (in_flush)
);

`default_nettype wire

// ==== sim/tb_ctrl.sv ====
//////////////////////////////
// controller testbench
// directed tests for boot, traps, interrupts, sleep and redirects
//////////////////////////////

`default_nettype none

module tb_ctrl;
  import ctrl_pkg::*;

  // the tests take about 150 cycles, so this leaves wide margin
  localparam int unsigned timeout_cycles = 2000;

  logic            clk_i = 1'b0;
  logic            rst_ni;
  instr_info_t     instr_i;
  lsu_err_t        lsu_i;
  irqs_t           irqs_i;
  logic            irq_nm_i;
  priv_lvl_e       priv_mode_i;
  logic            csr_mstatus_mie_i;
  logic            csr_mstatus_tw_i;
  logic            branch_set_i;
  logic            jump_set_i;
  logic            stall_id_i;
  logic            ctrl_busy_o;
  logic            instr_req_o;
  logic            id_in_ready_o;
  logic            instr_valid_clear_o;
  logic            flush_id_o;
  logic            controller_run_o;
  logic            pc_set_o;
  pc_sel_e         pc_mux_o;
  exc_pc_sel_e     exc_pc_mux_o;
  exc_cause_u      exc_cause_o;
  logic [xlen-1:0] csr_mtval_o;
  csr_ctrl_t       csr_o;
  logic            nmi_mode_o;

  int unsigned error_count = 0;
  int unsigned check_count = 0;
  int unsigned cycle_count = 0;

  ctrl_top #(
    .NumFastIrq (15)
  ) u_dut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_i             (instr_i),
    .lsu_i               (lsu_i),
    .irqs_i              (irqs_i),
    .irq_nm_i            (irq_nm_i),
    .priv_mode_i         (priv_mode_i),
    .csr_mstatus_mie_i   (csr_mstatus_mie_i),
    .csr_mstatus_tw_i    (csr_mstatus_tw_i),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .stall_id_i          (stall_id_i),
    .ctrl_busy_o         (ctrl_busy_o),
    .instr_req_o         (instr_req_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o),
    .controller_run_o    (controller_run_o),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .exc_pc_mux_o        (exc_pc_mux_o),
    .exc_cause_o         (exc_cause_o),
    .csr_mtval_o         (csr_mtval_o),
    .csr_o               (csr_o),
    .nmi_mode_o          (nmi_mode_o)
  );

  always #4 clk_i = ~clk_i;

  // run limit
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout, run stopped after %0d cycles", cycle_count);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    assert (act === exp) else begin
      error_count++;
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // outputs are sampled on the falling edge, away from input changes
  task automatic wait_redirect(input string name, input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!pc_set_o && n < limit);
    check_count++;
    assert (pc_set_o) else begin
      error_count++;
      $display("%s: no pc redirect within %0d cycles", name, limit);
    end
  endtask

  task automatic release_inputs();
    @(posedge clk_i);
    instr_i      <= '0;
    lsu_i        <= '0;
    irqs_i       <= '0;
    irq_nm_i     <= 1'b0;
    branch_set_i <= 1'b0;
    jump_set_i   <= 1'b0;
    stall_id_i   <= 1'b0;
  endtask

  // instruction held in ID, lsu error as a one cycle pulse
  // the trap has to show up in the cycle right after DECODE
  task automatic check_trap(input string name, input instr_info_t ins, input lsu_err_t lsu,
                            input exc_code_e exp_code, input logic [31:0] exp_mtval);
    @(posedge clk_i);
    instr_i <= ins;
    lsu_i   <= lsu;
    @(posedge clk_i);
    lsu_i.load_err  <= 1'b0;
    lsu_i.store_err <= 1'b0;
    wait_redirect(name, 1);
    check_value({name, " pc_mux"}, 32'(PC_EXC), 32'(pc_mux_o));
    check_value({name, " exc_pc_mux"}, 32'(EXC_PC_EXC), 32'(exc_pc_mux_o));
    check_value({name, " cause"}, 32'(exp_code), 32'(exc_cause_o));
    check_value({name, " mtval"}, exp_mtval, csr_mtval_o);
    check_value({name, " save_id save_cause"}, 32'd3, 32'({csr_o.save_id, csr_o.save_cause}));
    // the flush kills the trapping instruction in ID
    check_value({name, " flush_id"}, 32'd1, 32'(flush_id_o));
    check_value({name, " valid_clear"}, 32'd1, 32'(instr_valid_clear_o));
    release_inputs();
  endtask

  task automatic check_irq(input string name, input irqs_t irqs, input logic nm,
                           input logic [5:0] exp_cause);
    @(posedge clk_i);
    irqs_i   <= irqs;
    irq_nm_i <= nm;
    wait_redirect(name, 2);
    check_value({name, " pc_mux"}, 32'(PC_EXC), 32'(pc_mux_o));
    check_value({name, " exc_pc_mux"}, 32'(EXC_PC_IRQ), 32'(exc_pc_mux_o));
    check_value({name, " cause"}, 32'(exp_cause), 32'(exc_cause_o));
    check_value({name, " save_if save_cause"}, 32'd3, 32'({csr_o.save_if, csr_o.save_cause}));
    release_inputs();
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic boot_test();
    int n;
    n = 0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    // RESET then BOOT_SET, fetch only starts in the second
    @(negedge clk_i);
    check_value("boot first pc_set", 32'd1, 32'(pc_set_o));
    check_value("boot first pc_mux", 32'(PC_BOOT), 32'(pc_mux_o));
    check_value("boot first instr_req", 32'd0, 32'(instr_req_o));
    @(negedge clk_i);
    check_value("boot second pc_set", 32'd1, 32'(pc_set_o));
    check_value("boot second pc_mux", 32'(PC_BOOT), 32'(pc_mux_o));
    check_value("boot second instr_req", 32'd1, 32'(instr_req_o));
    @(negedge clk_i);
    check_value("boot third pc_set", 32'd0, 32'(pc_set_o));
    while (!controller_run_o && n < 3) begin
      @(negedge clk_i);
      n++;
    end
    check_value("boot controller_run", 32'd1, 32'(controller_run_o));
  endtask

  task automatic exception_test();
    instr_info_t ins;
    logic [31:0] pc;
    pc = $urandom & 32'hffff_fffe;
    // fetch fault beats illegal and ecall
    ins           = '0;
    ins.valid     = 1'b1;
    ins.fetch_err = 1'b1;
    ins.illegal   = 1'b1;
    ins.ecall     = 1'b1;
    ins.instr     = $urandom;
    ins.pc        = pc;
    check_trap("fetch fault", ins, '0, EXC_CAUSE_INSTR_ACCESS_FAULT, pc);
    ins.fetch_err_plus2 = 1'b1;
    check_trap("fetch fault plus2", ins, '0, EXC_CAUSE_INSTR_ACCESS_FAULT, pc + 32'd2);
    ins               = '0;
    ins.valid         = 1'b1;
    ins.illegal       = 1'b1;
    ins.is_compressed = 1'b1;
    ins.instr         = $urandom;
    ins.instr_c       = 16'($urandom);
    ins.pc            = pc;
    check_trap("compressed illegal", ins, '0, EXC_CAUSE_ILLEGAL_INSN, {16'h0, ins.instr_c});
    ins       = '0;
    ins.valid = 1'b1;
    ins.ecall = 1'b1;
    ins.pc    = pc;
    check_trap("ecall m-mode", ins, '0, EXC_CAUSE_ECALL_MMODE, 32'd0);
    priv_mode_i <= PRIV_LVL_U;
    check_trap("ecall u-mode", ins, '0, EXC_CAUSE_ECALL_UMODE, 32'd0);
    // mret out of U-mode traps with the instruction word
    ins       = '0;
    ins.valid = 1'b1;
    ins.mret  = 1'b1;
    ins.instr = 32'h3020_0073;
    ins.pc    = pc;
    check_trap("mret u-mode", ins, '0, EXC_CAUSE_ILLEGAL_INSN, 32'h3020_0073);
    priv_mode_i <= PRIV_LVL_M;
  endtask

  task automatic lsu_test();
    lsu_err_t lsu;
    lsu           = '0;
    lsu.load_err  = 1'b1;
    lsu.addr_last = $urandom;
    check_trap("load fault", '0, lsu, EXC_CAUSE_LOAD_ACCESS_FAULT, lsu.addr_last);
  endtask

  task automatic irq_test();
    irqs_t       irqs;
    irq_cause_t  fast_cause;
    instr_info_t ins;
    irqs              = '0;
    irqs.irq_fast[3]  = 1'b1;
    irqs.irq_fast[9]  = 1'b1;
    fast_cause.irq    = 1'b1;
    fast_cause.fast   = 1'b1;
    fast_cause.id     = 4'd9;
    csr_mstatus_mie_i <= 1'b1;
    check_irq("fast irq", irqs, 1'b0, fast_cause);
    // nmi is code 31 with the interrupt bit
    check_irq("nmi", irqs, 1'b1, {1'b1, 5'd31});
    @(negedge clk_i);
    check_value("nmi mode set", 32'd1, 32'(nmi_mode_o));
    @(posedge clk_i);
    irqs_i   <= irqs;
    irq_nm_i <= 1'b1;
    repeat (5) begin
      @(negedge clk_i);
      check_value("nmi blocks irq", 32'd0, 32'(pc_set_o));
    end
    release_inputs();
    // mret leaves the nmi handler
    ins       = '0;
    ins.valid = 1'b1;
    ins.mret  = 1'b1;
    ins.pc    = $urandom & 32'hffff_fffc;
    @(posedge clk_i);
    instr_i <= ins;
    wait_redirect("nmi mret", 2);
    check_value("nmi mret pc_mux", 32'(PC_ERET), 32'(pc_mux_o));
    check_value("nmi mret restore", 32'd1, 32'(csr_o.restore_mret));
    release_inputs();
    @(negedge clk_i);
    check_value("nmi mode cleared", 32'd0, 32'(nmi_mode_o));
    // masked by mie, nothing happens
    irqs              = '0;
    irqs.irq_software = 1'b1;
    @(posedge clk_i);
    csr_mstatus_mie_i <= 1'b0;
    irqs_i            <= irqs;
    repeat (5) begin
      @(negedge clk_i);
      check_value("mie clear", 32'd0, 32'(pc_set_o));
    end
    release_inputs();
  endtask

  task automatic sleep_test();
    instr_info_t ins;
    irqs_t       irqs;
    logic        went_low;
    int          n;
    ins               = '0;
    ins.valid         = 1'b1;
    ins.wfi           = 1'b1;
    ins.pc            = $urandom & 32'hffff_fffc;
    irqs              = '0;
    irqs.irq_software = 1'b1;
    went_low          = 1'b0;
    n                 = 0;
    csr_mstatus_mie_i <= 1'b1;
    @(posedge clk_i);
    instr_i <= ins;
    // FLUSH still needs the wfi flag
    @(posedge clk_i);
    @(posedge clk_i);
    instr_i <= '0;
    while (!went_low && n < 2) begin
      @(negedge clk_i);
      went_low = !ctrl_busy_o;
      n++;
    end
    check_count++;
    assert (went_low) else begin
      error_count++;
      $display("sleep: ctrl_busy_o did not drop within 3 cycles of WFI");
    end
    repeat (6) begin
      @(negedge clk_i);
      check_value("sleep busy low", 32'd0, 32'(ctrl_busy_o));
    end
    @(posedge clk_i);
    irqs_i <= irqs;
    @(negedge clk_i);
    check_value("wake busy", 32'd1, 32'(ctrl_busy_o));
    wait_redirect("wake irq", 2);
    check_value("wake exc_pc_mux", 32'(EXC_PC_IRQ), 32'(exc_pc_mux_o));
    // software interrupt is code 3 with the interrupt bit
    check_value("wake cause", 32'({1'b1, 5'd3}), 32'(exc_cause_o));
    release_inputs();
  endtask

  task automatic branch_test();
    @(posedge clk_i);
    branch_set_i <= 1'b1;
    @(negedge clk_i);
    check_value("branch pc_set", 32'd1, 32'(pc_set_o));
    check_value("branch pc_mux", 32'(PC_JUMP), 32'(pc_mux_o));
    release_inputs();
  endtask

  task automatic stall_test();
    @(posedge clk_i);
    stall_id_i <= 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_value("stall id ready", 32'd0, 32'(id_in_ready_o));
      // the stalled instruction stays valid in ID
      check_value("stall valid_clear", 32'd0, 32'(instr_valid_clear_o));
      check_value("stall flush_id", 32'd0, 32'(flush_id_o));
    end
    release_inputs();
    @(negedge clk_i);
    check_value("stall released ready", 32'd1, 32'(id_in_ready_o));
    check_value("stall released valid_clear", 32'd1, 32'(instr_valid_clear_o));
  endtask

  initial begin
    void'($urandom(32'h96860a81));
    rst_ni            = 1'b0;
    instr_i           = '0;
    lsu_i             = '0;
    irqs_i            = '0;
    irq_nm_i          = 1'b0;
    priv_mode_i       = PRIV_LVL_M;
    csr_mstatus_mie_i = 1'b0;
    csr_mstatus_tw_i  = 1'b0;
    branch_set_i      = 1'b0;
    jump_set_i        = 1'b0;
    stall_id_i        = 1'b0;
    boot_test();
    exception_test();
    lsu_test();
    irq_test();
    sleep_test();
    branch_test();
    stall_test();
    repeat (2) @(posedge clk_i);
    $display("summary: %0d checks, %0d errors, %0d assertion failures", check_count,
             error_count, u_dut.u_ctrl_assertions.fail_count);
    if (error_count == 0 && u_dut.u_ctrl_assertions.fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/ctrl_pkg.sv
rtl/exc_detect.sv
rtl/irq_arbiter.sv
rtl/ctrl_fsm.sv
rtl/ctrl_top.sv
sim/ctrl_assertions.sv
sim/tb_ctrl.sv
